/* verif/vec_unit_golden.txt */
# P reg word0 word1 word2 word3 (hex, word0 holds bytes 0-3 of the register)
# C vsew vl vstart mask opcode vd vs1 vs2 use_mask exp_word0 exp_word1 exp_word2 exp_word3 (hex)
P 0 00000000 00000000 00000000 00000000
P 1 80FF017F FFFFFFFF 00000001 12345678
P 2 01010101 00000001 FFFFFFFF 0F0F0F0F
P 3 A5A5A5A5 A5A5A5A5 A5A5A5A5 A5A5A5A5
P 4 44444444 4444C444 44444444 44444444
P 5 55555555 55555555 5555A555 55555555
P 6 66666666 66666666 66666666 6666E666
P 7 77777777 77777777 77777777 77777777
C 0 10 0 FFFF 0 0 2 1 0 81000280 FFFFFF00 FFFFFF00 21436587
C 1 8 0 FFFF 0 4 2 1 0 82000280 FFFF0000 FFFF0000 21436587
C 2 4 0 FFFF 0 5 2 1 0 82000280 00000000 00000000 21436587
C 3 2 0 FFFF 0 6 2 1 0 82000280 00000000 00000000 21436588
C 4 1 0 FFFF 1 7 2 1 0 7FFE007E FFFFFFFE 00000002 03254768
C 1 6 2 FFFF 1 0 2 1 0 81000280 FFFFFFFE 00010002 21436587
C 0 10 0 00F0 4 4 2 1 1 82000280 FFFFFFFE FFFF0000 21436587
C 2 4 0 0005 2 5 2 1 0 00010101 00000001 00000001 02040608
C 2 3 0 000A 3 6 2 1 1 82000280 FFFFFFFF 00000000 21436588

/* list.f */
hw/vec_pkg.sv
hw/vec_decode_element.sv
hw/vec_alu.sv
hw/vec_exec_seq.sv
hw/vec_regfile_arbiter.sv
hw/vec_regfile.sv
hw/vec_axil_regs.sv
hw/vec_unit_top.sv
verif/vec_unit_assertions.sv
verif/vec_unit_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= vec_unit_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/vec_unit_tb.sv */
/* Golden-file testbench for the vector unit over AXI4-Lite.
   All eight registers must be preloaded before any command row. */
module vec_unit_tb;
    import vec_pkg::*;

    logic        clk = 1'b0;
    logic        rst_n = 1'b0;
    logic [11:0] awaddr = '0, araddr = '0;
    logic        awvalid = 1'b0, wvalid = 1'b0, bready = 1'b0;
    logic        arvalid = 1'b0, rready = 1'b0;
    logic [31:0] wdata = '0;
    logic [3:0]  wstrb = '0;
    logic        awready, wready, bvalid, arready, rvalid;
    logic [1:0]  bresp, rresp;
    logic [31:0] rdata;

    logic [31:0] fld [64][13];
    bit          is_cmd [64];
    logic [31:0] model [8][4];
    int          nrows = 0;
    int          cycles = 0;
    int          limit = 0;

    vec_unit_top uut (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout: run exceeded %0d cycles", limit);
            stop_on_fail();
        end
    end

    task automatic stop_on_fail();
        $display("*** TEST FAILED ***");
        $fatal(1, "Run stopped");
    endtask

    task automatic check_val(string name, logic [31:0] exp, logic [31:0] got);
        assert (got === exp) else begin
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
            stop_on_fail();
        end
    endtask

    task automatic load_golden();
        int    fd;
        string line, tag;
        logic [31:0] v [13];
        fd = $fopen("verif/vec_unit_golden.txt", "r");
        if (fd == 0) begin
            $display("Cannot open golden file verif/vec_unit_golden.txt");
            stop_on_fail();
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line.substr(0, 0) == "#") continue;
            void'($sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h", tag,
                v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10],
                v[11], v[12]));
            is_cmd[nrows] = (tag == "C");
            for (int i = 0; i < 13; i++) fld[nrows][i] = v[i];
            nrows++;
        end
        $fclose(fd);
    endtask

    task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
                             input bit quick, output logic [1:0] resp);
        bit aw_hs, w_hs;
        if (!quick) repeat ($urandom_range(3, 0)) @(posedge clk);
        @(posedge clk);
        #1;
        awaddr = addr;
        awvalid = 1'b1;
        wdata = data;
        wstrb = 4'hF;
        wvalid = 1'b1;
        bready = quick;
        while (awvalid || wvalid) begin
            @(negedge clk);
            aw_hs = awvalid && awready;
            w_hs = wvalid && wready;
            @(posedge clk);
            #1;
            if (aw_hs) awvalid = 1'b0;
            if (w_hs) wvalid = 1'b0;
        end
        do @(negedge clk); while (!bvalid);
        resp = bresp;
        if (!bready) begin
            repeat ($urandom_range(3, 0)) @(posedge clk);
            @(posedge clk);
            #1;
            bready = 1'b1;
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [11:0] addr, input bit quick,
                            output logic [31:0] data, output logic [1:0] resp);
        bit ar_hs;
        if (!quick) repeat ($urandom_range(3, 0)) @(posedge clk);
        @(posedge clk);
        #1;
        araddr = addr;
        arvalid = 1'b1;
        rready = quick;
        do begin
            @(negedge clk);
            ar_hs = arready;
            @(posedge clk);
            #1;
        end while (!ar_hs);
        arvalid = 1'b0;
        do @(negedge clk); while (!rvalid);
        data = rdata;
        resp = rresp;
        if (!rready) begin
            repeat ($urandom_range(3, 0)) @(posedge clk);
            @(posedge clk);
            #1;
            rready = 1'b1;
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        rready = 1'b0;
    endtask

    task automatic preload_reg(int n);
        logic [1:0]  resp;
        logic [31:0] data;
        logic [11:0] base;
        base = 12'h100 + 12'(fld[n][0] * 16);
        for (int w = 0; w < 4; w++) begin
            axi_write(base + 12'(4 * w), fld[n][w + 1], 1'b0, resp);
            check_val("bresp", axi_resp_okay, resp);
            model[fld[n][0]][w] = fld[n][w + 1];
        end
        for (int w = 0; w < 4; w++) begin
            axi_read(base + 12'(4 * w), 1'b0, data, resp);
            check_val("rresp", axi_resp_okay, resp);
            check_val($sformatf("rdata r%0d word %0d", fld[n][0], w), fld[n][w + 1], data);
        end
    endtask

    task automatic exec_command(int n);
        logic [1:0]  resp;
        logic [1:0]  busy_resp;
        logic [31:0] data, cmd_word;
        int          vd, peek;
        vd = fld[n][5];
        peek = (vd + 1) % 8;
        axi_write(addr_vsew, fld[n][0], 1'b0, resp);
        check_val("bresp", axi_resp_okay, resp);
        axi_write(addr_vl, fld[n][1], 1'b0, resp);
        check_val("bresp", axi_resp_okay, resp);
        axi_write(addr_vstart, fld[n][2], 1'b0, resp);
        check_val("bresp", axi_resp_okay, resp);
        axi_write(addr_mask, fld[n][3], 1'b0, resp);
        check_val("bresp", axi_resp_okay, resp);
        cmd_word = fld[n][4] | (fld[n][5] << 4) | (fld[n][6] << 8) | (fld[n][7] << 12)
                   | (fld[n][8] << 16);
        axi_write(addr_cmd, cmd_word, 1'b1, resp);
        check_val("bresp", axi_resp_okay, resp);
        // Launch with another opcode and a window read, both during the running command
        fork
            axi_write(addr_cmd, cmd_word ^ 32'h1, 1'b1, busy_resp);
            axi_read(12'h100 + 12'(peek * 16), 1'b1, data, resp);
        join
        check_val("bresp of CMD while busy", axi_resp_slverr, busy_resp);
        check_val("rresp", axi_resp_okay, resp);
        check_val($sformatf("rdata r%0d word 0 while busy", peek), model[peek][0], data);
        do begin
            axi_read(addr_status, 1'b0, data, resp);
            check_val("rresp", axi_resp_okay, resp);
        end while (data[0]);
        for (int w = 0; w < 4; w++) begin
            axi_read(12'h100 + 12'(vd * 16 + 4 * w), 1'b0, data, resp);
            check_val("rresp", axi_resp_okay, resp);
            check_val($sformatf("vd r%0d word %0d", vd, w), fld[n][w + 9], data);
            model[vd][w] = fld[n][w + 9];
        end
    endtask

    initial begin
        void'($urandom(61));
        load_golden();
        limit = nrows * 200;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int n = 0; n < nrows; n++) begin
            if (is_cmd[n]) exec_command(n);
            else preload_reg(n);
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* verif/vec_unit_assertions.sv */
/* Protocol checks, bound once into the arbiter and once into the AXI block.
   Unused inputs of each binding are tied low. */
module vec_unit_assertions (
    input logic                 clk,
    input logic                 rst_n,
    input vec_pkg::vec_rf_req_t req,
    input logic                 gnt,
    input logic                 bvalid,
    input logic                 bready,
    input logic                 rvalid,
    input logic                 rready
);

    // A waiting host access keeps its request until granted
    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        req.req && !gnt |=> req.req && $stable(req.we) && $stable(req.addr)
            && (!req.we || $stable({req.wdata, req.be})))
        else $error("Register-file request changed before its grant");

    // Responses hold until accepted
    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

endmodule

bind vec_regfile_arbiter vec_unit_assertions u_arb_chk (
    .clk, .rst_n,
    .req (host_req), .gnt (host_rsp.gnt),
    .bvalid (1'b0), .bready (1'b0), .rvalid (1'b0), .rready (1'b0)
);

bind vec_axil_regs vec_unit_assertions u_axil_chk (
    .clk, .rst_n,
    .req ('0), .gnt (1'b0),
    .bvalid, .bready, .rvalid, .rready
);

/* hw/vec_unit_top.sv */
/* Vector execution unit, configured and fed over AXI4-Lite.
   Busy low in STATUS marks the end of a command. */
module vec_unit_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [11:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [11:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready
);
    import vec_pkg::*;

    vec_cfg_t      cfg;
    vec_cmd_t      cmd;
    logic          start;
    logic          busy;
    vec_rf_req_t   host_req, seq_req, rf_req;
    vec_rf_rsp_t   host_rsp, seq_rsp;
    vec_data_t     rf_rdata, srca, srcb, old_dst, result;
    vec_alu_opnd_t srca_alu, srcb_alu;

    vec_axil_regs u_axil (
        .clk, .rst_n,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready,
        .cfg, .cmd, .start, .busy, .host_req, .host_rsp
    );

    vec_exec_seq u_seq (
        .clk, .rst_n, .start, .cmd, .busy,
        .rf_req (seq_req),
        .rf_rsp (seq_rsp),
        .srca, .srcb, .old_dst, .result
    );

    // Command register stays put while busy, so its fields feed the datapath
    vec_decode_element u_decode (
        .cfg,
        .use_mask          (cmd.use_mask),
        .srca, .srcb, .srca_alu, .srcb_alu,
        .mask_result_valid ()
    );

    vec_alu u_alu (
        .opcode (cmd.opcode),
        .srca_alu, .srcb_alu, .old_dst, .result
    );

    vec_regfile_arbiter u_arb (
        .seq_req, .host_req, .seq_rsp, .host_rsp,
        .clk, .rst_n, .rf_req, .rf_rdata
    );

    vec_regfile u_rf (
        .clk, .rf_req,
        .rdata (rf_rdata)
    );

endmodule

/* hw/vec_axil_regs.sv */
/* AXI4-Lite slave with configuration, command, status and a data window.
   CMD word is opcode [2:0], vd [6:4], vs1 [10:8], vs2 [14:12], use_mask [16].
   Config writes act at once and ignore wstrb; do not change them while busy. */
module vec_axil_regs (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [11:0]          awaddr,
    input  logic                 awvalid,
    output logic                 awready,
    input  logic [31:0]          wdata,
    input  logic [3:0]           wstrb,
    input  logic                 wvalid,
    output logic                 wready,
    output logic [1:0]           bresp,
    output logic                 bvalid,
    input  logic                 bready,
    input  logic [11:0]          araddr,
    input  logic                 arvalid,
    output logic                 arready,
    output logic [31:0]          rdata,
    output logic [1:0]           rresp,
    output logic                 rvalid,
    input  logic                 rready,
    output vec_pkg::vec_cfg_t    cfg,
    output vec_pkg::vec_cmd_t    cmd,
    output logic                 start,
    input  logic                 busy,
    output vec_pkg::vec_rf_req_t host_req,
    input  vec_pkg::vec_rf_rsp_t host_rsp
);
    import vec_pkg::*;

    typedef enum logic [1:0] {W_IDLE, W_DEC, W_EXEC, W_RESP} wr_state_e;
    typedef enum logic [1:0] {R_IDLE, R_EXEC, R_DATA, R_RESP} rd_state_e;

    wr_state_e   wstate;
    rd_state_e   rstate;
    logic [11:0] wr_addr;
    logic [11:0] rd_addr;
    logic [31:0] wr_data;
    logic [3:0]  wr_strb;
    logic        aw_done, w_done, aw_have, w_have;
    logic        wr_err, wr_bad, wr_win, rd_win;
    logic        wr_rf, rd_rf, rd_gnt, rd_hold;
    logic [31:0] reg_rdata;
    logic        reg_rd_ok;

    assign aw_have = aw_done || (awvalid && awready);
    assign w_have  = w_done || (wvalid && wready);
    assign wr_win  = (wr_addr[11:7] == addr_win_page);
    assign rd_win  = (rd_addr[11:7] == addr_win_page);
    assign wr_bad  = wr_err || (wr_addr == addr_cmd && busy);

    // Window port, a read already waiting keeps it until granted
    assign wr_rf  = (wstate == W_EXEC) && wr_win && !rd_hold;
    assign rd_rf  = (rstate == R_EXEC) && rd_win && !wr_rf;
    assign rd_gnt = rd_rf && host_rsp.gnt;

    always_comb begin
        host_req.req   = wr_rf || rd_rf;
        host_req.we    = wr_rf;
        host_req.addr  = wr_rf ? wr_addr[6:4] : rd_addr[6:4];
        host_req.wdata = {4{wr_data}};
        host_req.be    = 16'(wr_strb) << {wr_addr[3:2], 2'b00};
    end

    always_comb begin
        reg_rdata = '0;
        reg_rd_ok = 1'b1;
        case (rd_addr)
            addr_cmd:    reg_rdata = {15'b0, cmd.use_mask, 1'b0, cmd.vs2, 1'b0, cmd.vs1,
                                      1'b0, cmd.vd, 1'b0, cmd.opcode};
            addr_vsew:   reg_rdata = 32'(cfg.vsew);
            addr_vl:     reg_rdata = 32'(cfg.vl);
            addr_vstart: reg_rdata = 32'(cfg.vstart);
            addr_mask:   reg_rdata = 32'(cfg.mask);
            addr_status: reg_rdata = 32'(busy);
            default:     reg_rd_ok = 1'b0;
        endcase
    end

    // Write path
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wstate  <= W_IDLE;
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            start   <= 1'b0;
            cfg     <= '{vsew: OSIZE_8, default: '0};
            cmd     <= '0;
        end else begin
            start <= 1'b0;
            case (wstate)
                W_IDLE: begin
                    // AW and W in either order
                    awready <= !aw_have;
                    wready  <= !w_have;
                    aw_done <= aw_have && !w_have;
                    w_done  <= w_have && !aw_have;
                    if (aw_have && w_have) wstate <= W_DEC;
                end
                W_DEC: wstate <= W_EXEC;
                W_EXEC: begin
                    if (!wr_win || (wr_rf && host_rsp.gnt)) begin
                        bvalid <= 1'b1;
                        wstate <= W_RESP;
                    end
                    if (!wr_bad && !wr_win) begin
                        case (wr_addr)
                            addr_cmd: begin
                                cmd   <= '{opcode: vec_opcode_e'(wr_data[2:0]),
                                           vd: wr_data[6:4], vs1: wr_data[10:8],
                                           vs2: wr_data[14:12], use_mask: wr_data[16]};
                                start <= 1'b1;
                            end
                            addr_vsew:   cfg.vsew   <= vec_osize_e'(wr_data[2:0]);
                            addr_vl:     cfg.vl     <= wr_data[4:0];
                            addr_vstart: cfg.vstart <= wr_data[4:0];
                            addr_mask:   cfg.mask   <= wr_data[15:0];
                            default: ;
                        endcase
                    end
                end
                default: if (bready) begin
                    bvalid <= 1'b0;
                    wstate <= W_IDLE;
                end
            endcase
        end
    end

    // Read path
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rstate  <= R_IDLE;
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rd_hold <= 1'b0;
        end else begin
            rd_hold <= rd_rf && !rd_gnt;
            case (rstate)
                R_IDLE: begin
                    arready <= !(arvalid && arready);
                    if (arvalid && arready) rstate <= R_EXEC;
                end
                R_EXEC: begin
                    if (!rd_win) begin
                        rvalid <= 1'b1;
                        rstate <= R_RESP;
                    end else if (rd_gnt) begin
                        rstate <= R_DATA;
                    end
                end
                R_DATA: begin
                    rvalid <= 1'b1;
                    rstate <= R_RESP;
                end
                default: if (rready) begin
                    rvalid <= 1'b0;
                    rstate <= R_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (awvalid && awready) wr_addr <= awaddr;
        if (wvalid && wready) begin
            wr_data <= wdata;
            wr_strb <= wstrb;
        end
        if (wstate == W_DEC) begin
            wr_err <= !wr_win && !(wr_addr inside {addr_cmd, addr_vsew, addr_vl,
                                                  addr_vstart, addr_mask});
        end
        if (wstate == W_EXEC) bresp <= wr_bad ? axi_resp_slverr : axi_resp_okay;
        if (arvalid && arready) rd_addr <= araddr;
        if (rstate == R_EXEC && !rd_win) begin
            rdata <= reg_rdata;
            rresp <= reg_rd_ok ? axi_resp_okay : axi_resp_slverr;
        end
        if (rstate == R_DATA) begin
            rdata <= host_rsp.rdata[{rd_addr[3:2], 5'b0} +: 32];
            rresp <= axi_resp_okay;
        end
    end

endmodule

/* hw/vec_regfile.sv */
/* Eight 128-bit vector registers with byte enables.
   Read data is registered and holds until the next read. */
module vec_regfile (
    input  logic                 clk,
    input  vec_pkg::vec_rf_req_t rf_req,
    output vec_pkg::vec_data_t   rdata
);
    import vec_pkg::*;

    vec_data_t mem [vec_num_regs];

    always_ff @(posedge clk) begin
        if (rf_req.req) begin
            if (rf_req.we) begin
                for (int b = 0; b < vec_num_bytes; b++) begin
                    if (rf_req.be[b]) mem[rf_req.addr][8*b +: 8] <= rf_req.wdata[8*b +: 8];
                end
            end else begin
                rdata <= mem[rf_req.addr];
            end
        end
    end

endmodule

/* hw/vec_regfile_arbiter.sv */
/* Fixed-priority arbiter for the single register-file port, sequencer first.
   Grant is combinational; read data is routed to the reader one cycle later. */
module vec_regfile_arbiter (
    input  vec_pkg::vec_rf_req_t seq_req,
    input  vec_pkg::vec_rf_req_t host_req,
    output vec_pkg::vec_rf_rsp_t seq_rsp,
    output vec_pkg::vec_rf_rsp_t host_rsp,
    input  logic                 clk,
    input  logic                 rst_n,
    output vec_pkg::vec_rf_req_t rf_req,
    input  vec_pkg::vec_data_t   rf_rdata
);
    logic seq_gnt;
    logic host_gnt;
    logic seq_rd_q;
    logic host_rd_q;

    assign seq_gnt  = seq_req.req;
    assign host_gnt = host_req.req && !seq_req.req;

    assign rf_req = seq_req.req ? seq_req : host_req;

    // Owner of last cycle's read
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            seq_rd_q  <= 1'b0;
            host_rd_q <= 1'b0;
        end else begin
            seq_rd_q  <= seq_gnt && !seq_req.we;
            host_rd_q <= host_gnt && !host_req.we;
        end
    end

    assign seq_rsp.gnt    = seq_gnt;
    assign seq_rsp.rdata  = seq_rd_q ? rf_rdata : '0;
    assign host_rsp.gnt   = host_gnt;
    assign host_rsp.rdata = host_rd_q ? rf_rdata : '0;

endmodule

/* hw/vec_exec_seq.sv */
/* Command sequencer. Reads vs1, vs2 and vd, then writes vd with all byte enables.
   Operand order follows RVV, so srca is vs2 and srcb is vs1 (vd = vs2 op vs1).
   One command at a time; start is ignored while busy. */
module vec_exec_seq (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  vec_pkg::vec_cmd_t    cmd,
    output logic                 busy,
    output vec_pkg::vec_rf_req_t rf_req,
    input  vec_pkg::vec_rf_rsp_t rf_rsp,
    output vec_pkg::vec_data_t   srca,
    output vec_pkg::vec_data_t   srcb,
    output vec_pkg::vec_data_t   old_dst,
    input  vec_pkg::vec_data_t   result
);
    import vec_pkg::*;

    typedef enum logic [2:0] {IDLE, RD_VS1, RD_VS2, RD_VD, WR_VD} seq_state_e;

    seq_state_e state;
    vec_cmd_t   cmd_q;
    logic       rd_pend;
    vec_data_t  vs1_q;
    vec_data_t  vs2_q;
    vec_data_t  vd_q;

    assign busy = (state != IDLE);

    always_comb begin
        case (state)
            RD_VS1:  rf_req.addr = cmd_q.vs1;
            RD_VS2:  rf_req.addr = cmd_q.vs2;
            default: rf_req.addr = cmd_q.vd;
        endcase
        // No request while waiting for read data
        rf_req.req   = busy && !rd_pend;
        rf_req.we    = (state == WR_VD);
        rf_req.wdata = result;
        rf_req.be    = '1;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= IDLE;
            rd_pend <= 1'b0;
        end else begin
            case (state)
                IDLE: if (start) state <= RD_VS1;
                RD_VS1, RD_VS2, RD_VD: begin
                    if (rd_pend) begin
                        rd_pend <= 1'b0;
                        state   <= (state == RD_VS1) ? RD_VS2 :
                                   (state == RD_VS2) ? RD_VD : WR_VD;
                    end else if (rf_rsp.gnt) begin
                        rd_pend <= 1'b1;
                    end
                end
                WR_VD:   if (rf_rsp.gnt) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Operands load in the cycle after their grant
    always_ff @(posedge clk) begin
        if (state == IDLE && start) cmd_q <= cmd;
        if (rd_pend && state == RD_VS1) vs1_q <= rf_rsp.rdata;
        if (rd_pend && state == RD_VS2) vs2_q <= rf_rsp.rdata;
        if (rd_pend && state == RD_VD)  vd_q  <= rf_rsp.rdata;
    end

    assign srca    = vs2_q;
    assign srcb    = vs1_q;
    assign old_dst = vd_q;

endmodule

/* hw/vec_alu.sv */
/* Byte-lane vector ALU. Subtract gives srca - srcb per element.
   Inactive bytes and unknown opcodes return old_dst unchanged. */
module vec_alu (
    input  vec_pkg::vec_opcode_e   opcode,
    input  vec_pkg::vec_alu_opnd_t srca_alu,
    input  vec_pkg::vec_alu_opnd_t srcb_alu,
    input  vec_pkg::vec_data_t     old_dst,
    output vec_pkg::vec_data_t     result
);
    import vec_pkg::*;

    logic is_sub;

    assign is_sub = (opcode == OP_SUB);

    always_comb begin
        logic [7:0] a_byte;
        logic [7:0] b_byte;
        logic [7:0] r_byte;
        logic [8:0] sum;
        logic       carry;

        // Subtract is a + ~b + 1, the +1 entering at each element's low byte
        carry  = is_sub;
        result = old_dst;
        for (int i = 0; i < vec_num_bytes; i++) begin
            a_byte = srca_alu.data[8*i +: 8];
            b_byte = srcb_alu.data[8*i +: 8];
            sum    = {1'b0, a_byte} + {1'b0, is_sub ? ~b_byte : b_byte} + 9'(carry);
            // Carry passes on only inside an element
            carry  = srca_alu.merge[i] ? sum[8] : is_sub;

            case (opcode)
                OP_ADD,
                OP_SUB:  r_byte = sum[7:0];
                OP_AND:  r_byte = a_byte & b_byte;
                OP_OR:   r_byte = a_byte | b_byte;
                OP_XOR:  r_byte = a_byte ^ b_byte;
                default: r_byte = old_dst[8*i +: 8];
            endcase

            // Undisturbed policy for inactive bytes
            if (srca_alu.valid[i] && srcb_alu.valid[i]) begin
                result[8*i +: 8] = r_byte;
            end
        end
    end

endmodule

/* hw/vec_decode_element.sv */
/* Combinational decode of vsew, vl, vstart and the element mask into per-byte
   valid and carry-merge bits. A vsew code above OSIZE_128 leaves every byte inactive. */
module vec_decode_element (
    input  vec_pkg::vec_cfg_t      cfg,
    input  logic                   use_mask,
    input  vec_pkg::vec_data_t     srca,
    input  vec_pkg::vec_data_t     srcb,
    output vec_pkg::vec_alu_opnd_t srca_alu,
    output vec_pkg::vec_alu_opnd_t srcb_alu,
    output vec_pkg::vec_mask_t     mask_result_valid
);
    import vec_pkg::*;

    vec_osize_vec_t osize_vec;
    vec_mask_t      valid_osize [vec_num_osizes];
    vec_mask_t      mask_osize  [vec_num_osizes];
    vec_mask_t      merge_osize [vec_num_osizes];
    vec_mask_t      valid_sel;
    vec_mask_t      mask_sel;
    vec_mask_t      merge_sel;
    vec_mask_t      mask_valid;

    // One-hot element size
    for (genvar o = 0; o < vec_num_osizes; o++) begin : gen_osize_vec
        assign osize_vec[o] = (cfg.vsew == vec_osize_e'(o));
    end

    // Element is live when vstart <= idx < vl
    for (genvar e = 0; e < vec_num_elements; e++) begin : gen_len_start
        assign mask_result_valid[e] = (5'(e) < cfg.vl) && (5'(e) >= cfg.vstart);
    end

    // Per-size byte maps, element e of size o covers bytes e*2^o upward
    for (genvar o = 0; o < vec_num_osizes; o++) begin : gen_osize
        for (genvar e = 0; e < (vec_num_bytes >> o); e++) begin : gen_elem
            assign valid_osize[o][e*(1<<o) +: (1<<o)] =
                {(1<<o){mask_result_valid[e] & osize_vec[o]}};
            assign mask_osize[o][e*(1<<o) +: (1<<o)] =
                {(1<<o){cfg.mask[e] & osize_vec[o]}};
        end
        // Top byte of each element stops the carry
        for (genvar b = 0; b < vec_num_bytes; b++) begin : gen_merge
            assign merge_osize[o][b] = osize_vec[o] && ((b % (1 << o)) != (1 << o) - 1);
        end
    end

    // Only one size is selected, so OR-ing the maps picks it
    always_comb begin
        valid_sel = '0;
        mask_sel  = '0;
        merge_sel = '0;
        for (int o = 0; o < vec_num_osizes; o++) begin
            valid_sel |= valid_osize[o];
            mask_sel  |= mask_osize[o];
            merge_sel |= merge_osize[o];
        end
    end

    // Mask only counts when the command asks for it
    assign mask_valid = {vec_num_bytes{~use_mask}} | mask_sel;

    assign srca_alu.data  = srca;
    assign srca_alu.valid = valid_sel & mask_valid;
    assign srca_alu.merge = merge_sel;

    assign srcb_alu.data  = srcb;
    assign srcb_alu.valid = valid_sel & mask_valid;
    assign srcb_alu.merge = merge_sel;

endmodule

/* hw/vec_pkg.sv */
/* Shared constants and types of the vector unit.
   Register geometry is fixed at eight registers of 16 bytes, elements of 8 to 128 bits. */
package vec_pkg;

    localparam int vec_num_bytes    = 16;
    localparam int vec_num_regs     = 8;
    localparam int vec_num_osizes   = 5;
    localparam int vec_num_elements = vec_num_bytes;
    localparam int vec_reg_addr_w   = 3;

    // AXI4-Lite response codes
    localparam logic [1:0] axi_resp_okay   = 2'b00;
    localparam logic [1:0] axi_resp_slverr = 2'b10;

    // Register map
    localparam logic [11:0] addr_cmd    = 12'h000;
    localparam logic [11:0] addr_vsew   = 12'h004;
    localparam logic [11:0] addr_vl     = 12'h008;
    localparam logic [11:0] addr_vstart = 12'h00C;
    localparam logic [11:0] addr_mask   = 12'h010;
    localparam logic [11:0] addr_status = 12'h014;
    // Data window 0x100-0x17F, compared on addr[11:7]
    localparam logic [4:0]  addr_win_page = 5'h02;

    typedef enum logic [2:0] {
        OSIZE_8,
        OSIZE_16,
        OSIZE_32,
        OSIZE_64,
        OSIZE_128
    } vec_osize_e;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR
    } vec_opcode_e;

    typedef logic [8*vec_num_bytes-1:0]  vec_data_t;
    typedef logic [vec_num_elements-1:0] vec_mask_t;
    typedef logic [vec_num_osizes-1:0]   vec_osize_vec_t;

    typedef struct packed {
        vec_osize_e vsew;
        logic [4:0] vl;
        logic [4:0] vstart;
        vec_mask_t  mask;
    } vec_cfg_t;

    typedef struct packed {
        vec_opcode_e               opcode;
        logic [vec_reg_addr_w-1:0] vd;
        logic [vec_reg_addr_w-1:0] vs1;
        logic [vec_reg_addr_w-1:0] vs2;
        logic                      use_mask;
    } vec_cmd_t;

    typedef struct packed {
        vec_data_t                data;
        logic [vec_num_bytes-1:0] valid;
        logic [vec_num_bytes-1:0] merge;
    } vec_alu_opnd_t;

    typedef struct packed {
        logic                      req;
        logic                      we;
        logic [vec_reg_addr_w-1:0] addr;
        vec_data_t                 wdata;
        logic [vec_num_bytes-1:0]  be;
    } vec_rf_req_t;

    typedef struct packed {
        logic      gnt;
        vec_data_t rdata;
    } vec_rf_rsp_t;

endpackage
